//--- sh_exec_core.f
design/sh_pkg.sv
design/sh_regfile.sv
design/sh_ex_stage.sv
design/sh_alu.sv
design/sh_mem_lane.sv
design/sh_writeback.sv
design/sh_exec_core.sv
verif/sh_exec_checker.sv
verif/tb_sh_exec_core.sv

//--- run.sh
#!/bin/sh
# Build and run; the log decides the result
rm -f sim.log
{ verilator --binary --timing --assert --top-module tb_sh_exec_core \
	-f sh_exec_core.f -o vsim > sim.log 2>&1 &&
	./obj_dir/vsim >> sim.log 2>&1; } ||
	echo "TESTS FAILED" >> sim.log
cat sim.log
! grep -q "TESTS FAILED" sim.log

//--- verif/tb_sh_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sh_exec_core;

	typedef struct packed {
		sh_pkg::alu_op_t   op;
		sh_pkg::mem_op_t   mem;
		sh_pkg::mem_size_t size;
		logic [3:0]        rn;
		logic [3:0]        rm;
		logic [7:0]        imm;
		logic              we;
		logic [31:0]       data;
		logic              t;
		logic [3:0]        ba;
		logic [31:0]       dout;
		logic [31:0]       addr;
	} entry_t;

	logic              CLK;
	logic              RST_N = 1'b0;
	logic              issue = 1'b0;
	logic              ready;
	sh_pkg::alu_op_t   op = sh_pkg::NOP;
	sh_pkg::mem_op_t   mem = sh_pkg::MEM_NONE;
	sh_pkg::mem_size_t size = sh_pkg::SZ_BYTE;
	logic [3:0]        rn = '0;
	logic [3:0]        rm = '0;
	logic [7:0]        imm = '0;
	logic [31:0]       BUS_A;
	logic [31:0]       BUS_DO;
	logic [31:0]       BUS_DI;
	logic              BUS_WR;
	logic              BUS_REQ;
	logic [3:0]        BUS_BA;
	logic              BUS_WAIT = 1'b0;
	logic              wb_valid;
	logic              wb_we;
	logic [3:0]        wb_reg;
	logic [31:0]       wb_data;
	logic              t_flag;

	entry_t            tbl[$];
	longint            acc_time[64];
	logic [31:0]       words[16];
	logic              s_req;
	logic              s_wait;
	logic              s_wr;
	logic [3:0]        s_ba;
	logic [31:0]       s_do;
	logic [31:0]       s_a;
	int                wait_left;
	int                mem_idx;

	sh_exec_core dut (
		.CLK(CLK), .RST_N(RST_N), .issue(issue), .ready(ready),
		.op(op), .mem(mem), .size(size), .rn(rn), .rm(rm), .imm(imm),
		.BUS_A(BUS_A), .BUS_DO(BUS_DO), .BUS_DI(BUS_DI), .BUS_WR(BUS_WR),
		.BUS_REQ(BUS_REQ), .BUS_BA(BUS_BA), .BUS_WAIT(BUS_WAIT),
		.wb_valid(wb_valid), .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
		.t_flag(t_flag)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	endtask

	//************************************************************
	// Word memory bus model with 0 to 2 wait cycles per access
	//************************************************************
	assign BUS_DI = words[BUS_A[5:2]];

	always @(negedge CLK) begin
		s_req  <= BUS_REQ;
		s_wait <= BUS_WAIT;
		s_wr   <= BUS_WR;
		s_ba   <= BUS_BA;
		s_do   <= BUS_DO;
		s_a    <= BUS_A;
	end

	always @(posedge CLK) begin
		if (!RST_N) begin
			for (int i = 0; i < 16; i++) begin
				words[i] <= 32'h1000_0000 + i * 32'h0101_0101;
			end
			wait_left = 0;
			mem_idx = 0;
		end else if (s_req && s_wait) begin
			wait_left = wait_left - 1;
			BUS_WAIT <= (wait_left > 0);
		end else begin
			if (s_req) begin
				while (mem_idx < tbl.size() && tbl[mem_idx].mem == sh_pkg::MEM_NONE) begin
					mem_idx++;
				end
				if (mem_idx >= tbl.size()) begin
					$display("Bus access at %0t with no memory instruction left", $time);
					$display("TESTS FAILED");
					$fatal(1, "unexpected bus access");
				end else begin
					check_value("BUS_A", s_a, tbl[mem_idx].addr);
					check_value("BUS_WR", 32'(s_wr),
						32'(tbl[mem_idx].mem == sh_pkg::MEM_STORE));
					if (s_wr) begin
						check_value("BUS_BA", 32'(s_ba), 32'(tbl[mem_idx].ba));
						check_value("BUS_DO", s_do, tbl[mem_idx].dout);
						for (int j = 0; j < 4; j++) begin
							if (s_ba[j]) words[s_a[5:2]][8*j +: 8] <= s_do[8*j +: 8];
						end
					end
					mem_idx++;
				end
			end
			wait_left = int'($urandom % 3);
			BUS_WAIT <= (wait_left != 0);
		end
	end

	//************************************************************
	// Stimulus table
	//************************************************************
	task automatic add_alu(input sh_pkg::alu_op_t o, input logic [3:0] n, input logic [3:0] m,
		input logic [7:0] i, input logic w, input logic [31:0] d, input logic t);
		tbl.push_back('{o, sh_pkg::MEM_NONE, sh_pkg::SZ_LONG, n, m, i, w, d, t,
			4'h0, 32'h0, 32'h0});
	endtask

	task automatic add_load(input sh_pkg::mem_size_t s, input logic [3:0] n,
		input logic [3:0] m, input logic [31:0] a, input logic [31:0] d);
		tbl.push_back('{sh_pkg::NOP, sh_pkg::MEM_LOAD, s, n, m, 8'h0, 1'b1, d, 1'b0,
			4'h0, 32'h0, a});
	endtask

	task automatic add_store(input sh_pkg::mem_size_t s, input logic [3:0] n,
		input logic [3:0] m, input logic [31:0] a, input logic [3:0] ba,
		input logic [31:0] dout);
		tbl.push_back('{sh_pkg::NOP, sh_pkg::MEM_STORE, s, n, m, 8'h0, 1'b0, 32'h0, 1'b0,
			ba, dout, a});
	endtask

	task automatic build_table();
		add_alu(sh_pkg::MOVI,   1, 0, 8'h7f, 1, 32'h0000007f, 0);
		add_alu(sh_pkg::MOVI,   2, 0, 8'h80, 1, 32'hffffff80, 0);
		add_alu(sh_pkg::ADD,    1, 2, 8'h00, 1, 32'hffffffff, 0);
		add_alu(sh_pkg::SUB,    2, 1, 8'h00, 1, 32'hffffff81, 0);
		add_alu(sh_pkg::MOV,    3, 2, 8'h00, 1, 32'hffffff81, 0);
		add_alu(sh_pkg::AND,    3, 1, 8'h00, 1, 32'hffffff81, 0);
		add_alu(sh_pkg::MOVI,   4, 0, 8'h3c, 1, 32'h0000003c, 0);
		add_alu(sh_pkg::OR,     4, 3, 8'h00, 1, 32'hffffffbd, 0);
		add_alu(sh_pkg::XOR,    4, 2, 8'h00, 1, 32'h0000003c, 0);
		add_alu(sh_pkg::EXTU_B, 5, 2, 8'h00, 1, 32'h00000081, 0);
		add_alu(sh_pkg::EXTS_B, 6, 2, 8'h00, 1, 32'hffffff81, 0);
		add_alu(sh_pkg::CMP_EQ, 3, 6, 8'h00, 0, 32'h0, 1);
		add_alu(sh_pkg::CMP_HS, 5, 6, 8'h00, 0, 32'h0, 0);
		add_alu(sh_pkg::CMP_GE, 5, 6, 8'h00, 0, 32'h0, 1);
		// Carry in comes from the CMP_GE just ahead
		add_alu(sh_pkg::ADDC,   1, 1, 8'h00, 1, 32'hffffffff, 1);
		add_alu(sh_pkg::TST,    5, 2, 8'h00, 0, 32'h0, 0);
		add_alu(sh_pkg::ADDC,   4, 5, 8'h00, 1, 32'h000000bd, 0);
		add_alu(sh_pkg::MOVI,   7, 0, 8'h20, 1, 32'h00000020, 0);
		add_alu(sh_pkg::MOVI,   8, 0, 8'h11, 1, 32'h00000011, 0);
		add_store(sh_pkg::SZ_LONG, 2, 7, 32'h20, 4'b1111, 32'hffffff81);
		add_alu(sh_pkg::MOVI,   9, 0, 8'h04, 1, 32'h00000004, 0);
		add_alu(sh_pkg::ADD,    7, 9, 8'h00, 1, 32'h00000024, 0);
		add_alu(sh_pkg::MOVI,   9, 0, 8'h01, 1, 32'h00000001, 0);
		add_store(sh_pkg::SZ_BYTE, 8, 7, 32'h24, 4'b1000, 32'h11111111);
		add_alu(sh_pkg::ADD,    7, 9, 8'h00, 1, 32'h00000025, 0);
		add_store(sh_pkg::SZ_BYTE, 5, 7, 32'h25, 4'b0100, 32'h81818181);
		add_alu(sh_pkg::ADD,    7, 9, 8'h00, 1, 32'h00000026, 0);
		add_store(sh_pkg::SZ_BYTE, 4, 7, 32'h26, 4'b0010, 32'hbdbdbdbd);
		add_alu(sh_pkg::ADD,    7, 9, 8'h00, 1, 32'h00000027, 0);
		add_store(sh_pkg::SZ_BYTE, 8, 7, 32'h27, 4'b0001, 32'h11111111);
		add_alu(sh_pkg::ADD,    7, 9, 8'h00, 1, 32'h00000028, 0);
		add_store(sh_pkg::SZ_WORD, 2, 7, 32'h28, 4'b1100, 32'hff81ff81);
		add_alu(sh_pkg::MOVI,   9, 0, 8'h02, 1, 32'h00000002, 0);
		add_alu(sh_pkg::ADD,    7, 9, 8'h00, 1, 32'h0000002a, 0);
		add_store(sh_pkg::SZ_WORD, 4, 7, 32'h2a, 4'b0011, 32'h00bd00bd);
		add_load(sh_pkg::SZ_WORD, 10, 7, 32'h2a, 32'h000000bd);
		add_alu(sh_pkg::MOVI,  11, 0, 8'h24, 1, 32'h00000024, 0);
		add_load(sh_pkg::SZ_BYTE, 12, 11, 32'h24, 32'h00000011);
		add_alu(sh_pkg::ADD,   11, 9, 8'h00, 1, 32'h00000026, 0);
		add_load(sh_pkg::SZ_BYTE, 12, 11, 32'h26, 32'hffffffbd);
		add_alu(sh_pkg::MOVI,  13, 0, 8'h28, 1, 32'h00000028, 0);
		add_load(sh_pkg::SZ_WORD, 14, 13, 32'h28, 32'hffffff81);
		add_alu(sh_pkg::MOVI,  13, 0, 8'h20, 1, 32'h00000020, 0);
		add_load(sh_pkg::SZ_LONG, 15, 13, 32'h20, 32'hffffff81);
		add_alu(sh_pkg::MOVI,  13, 0, 8'h24, 1, 32'h00000024, 0);
		add_load(sh_pkg::SZ_LONG, 15, 13, 32'h24, 32'h1181bd11);
		add_alu(sh_pkg::ADD,   15, 12, 8'h00, 1, 32'h1181bcce, 0);
		add_alu(sh_pkg::SHLL,  15, 0, 8'h00, 1, 32'h2303799c, 0);
		add_alu(sh_pkg::SHLR,  12, 0, 8'h00, 1, 32'h7fffffde, 1);
		add_alu(sh_pkg::NOP,    0, 0, 8'h00, 0, 32'h0, 1);
	endtask

	// One instruction per accepted edge, so dependences hit the bypasses
	task automatic issue_all();
		int  n;
		logic r;
		for (int k = 0; k < tbl.size(); k++) begin
			issue <= 1'b1;
			op    <= tbl[k].op;
			mem   <= tbl[k].mem;
			size  <= tbl[k].size;
			rn    <= tbl[k].rn;
			rm    <= tbl[k].rm;
			imm   <= tbl[k].imm;
			n = 0;
			r = 1'b0;
			while (!r) begin
				@(negedge CLK);
				r = ready;
				@(posedge CLK);
				n++;
				if (!r && n > 50) stop_on_timeout("ready stayed low");
			end
			acc_time[k] = $time;
		end
		issue <= 1'b0;
	endtask

	task automatic collect_all();
		int   n;
		logic pend;
		logic pend_t;
		pend = 1'b0;
		pend_t = 1'b0;
		for (int k = 0; k < tbl.size(); k++) begin
			n = 0;
			do begin
				@(negedge CLK);
				if (pend) begin
					check_value("t_flag", 32'(t_flag), 32'(pend_t));
					pend = 1'b0;
				end
				n++;
				if (!wb_valid && n > 60) stop_on_timeout("wb_valid stayed low");
			end while (!wb_valid);
			check_value("wb_we", 32'(wb_we), 32'(tbl[k].we));
			check_value("wb_reg", 32'(wb_reg), 32'(tbl[k].rn));
			if (tbl[k].we) check_value("wb_data", wb_data, tbl[k].data);
			// Accept edge plus one edge, seen at the following falling edge
			if (tbl[k].mem == sh_pkg::MEM_NONE) begin
				check_value("wb_latency", 32'($time - acc_time[k]), 32'd150);
			end
			pend = 1'b1;
			pend_t = tbl[k].t;
		end
		@(negedge CLK);
		check_value("t_flag", 32'(t_flag), 32'(pend_t));
	endtask

	initial begin
		void'($urandom(32'h403b671e));
		build_table();
		repeat (9) @(posedge CLK);
		@(negedge CLK);
		check_value("ready", 32'(ready), 32'd1);
		check_value("BUS_REQ", 32'(BUS_REQ), 32'd0);
		check_value("wb_valid", 32'(wb_valid), 32'd0);
		check_value("t_flag", 32'(t_flag), 32'd0);
		@(posedge CLK);
		RST_N <= 1'b1;
		fork
			issue_all();
			collect_all();
		join
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/sh_exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sh_exec_checker (
	input wire        CLK,
	input wire        RST_N,
	input wire        issue,
	input wire        ready,
	input wire [31:0] BUS_A,
	input wire        BUS_WR,
	input wire        BUS_REQ,
	input wire [3:0]  BUS_BA,
	input wire        BUS_WAIT,
	input wire        wb_valid
);

	a_wr_needs_req: assert property (@(posedge CLK) disable iff (!RST_N)
		BUS_WR |-> BUS_REQ) else $error("BUS_WR without BUS_REQ");

	// Access fields hold while the bus waits
	a_bus_stable: assert property (@(posedge CLK) disable iff (!RST_N)
		(BUS_REQ && BUS_WAIT) |=> ($stable(BUS_A) && $stable(BUS_WR) && $stable(BUS_BA)))
		else $error("bus access changed during wait");

	a_ready_idle: assert property (@(posedge CLK) disable iff (!RST_N)
		!BUS_REQ |-> ready) else $error("ready low with no bus access");

	// Two write-back cycles in a row need two accepted instructions
	a_wb_once: assert property (@(posedge CLK) disable iff (!RST_N)
		(wb_valid && $past(wb_valid)) |-> $past(issue && ready, 2))
		else $error("wb_valid repeated for one instruction");

endmodule

bind sh_exec_core sh_exec_checker u_checker (
	.CLK(CLK), .RST_N(RST_N), .issue(issue), .ready(ready),
	.BUS_A(BUS_A), .BUS_WR(BUS_WR), .BUS_REQ(BUS_REQ), .BUS_BA(BUS_BA),
	.BUS_WAIT(BUS_WAIT), .wb_valid(wb_valid)
);

`default_nettype wire

//--- design/sh_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module sh_exec_core (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire                        issue,
	output logic                       ready,
	input  sh_pkg::alu_op_t            op,
	input  sh_pkg::mem_op_t            mem,
	input  sh_pkg::mem_size_t          size,
	input  wire [sh_pkg::reg_n_w-1:0]  rn,
	input  wire [sh_pkg::reg_n_w-1:0]  rm,
	input  wire [7:0]                  imm,
	output logic [sh_pkg::data_w-1:0]  BUS_A,
	output logic [sh_pkg::data_w-1:0]  BUS_DO,
	input  wire [sh_pkg::data_w-1:0]   BUS_DI,
	output logic                       BUS_WR,
	output logic                       BUS_REQ,
	output logic [3:0]                 BUS_BA,
	input  wire                        BUS_WAIT,
	output logic                       wb_valid,
	output logic                       wb_we,
	output logic [sh_pkg::reg_n_w-1:0] wb_reg,
	output logic [sh_pkg::data_w-1:0]  wb_data,
	output logic                       t_flag
);

	logic [sh_pkg::reg_n_w-1:0] ra_n;
	logic [sh_pkg::reg_n_w-1:0] rb_n;
	logic [sh_pkg::data_w-1:0]  ra_q;
	logic [sh_pkg::data_w-1:0]  rb_q;
	logic [sh_pkg::reg_n_w-1:0] w_n;
	logic [sh_pkg::data_w-1:0]  w_d;
	logic                       w_en;

	logic                       ex_valid;
	logic                       ex_done;
	sh_pkg::alu_op_t            ex_op;
	sh_pkg::mem_op_t            ex_mem;
	sh_pkg::mem_size_t          ex_size;
	logic [sh_pkg::reg_n_w-1:0] ex_rn;
	logic [7:0]                 ex_imm;

	logic [sh_pkg::data_w-1:0]  alu_res;
	logic                       alu_t;
	logic                       alu_t_we;
	logic                       alu_r_we;
	logic [sh_pkg::data_w-1:0]  ld_data;
	logic                       t_cur;

	sh_regfile u_regfile (
		.CLK(CLK), .RST_N(RST_N),
		.ra_n(ra_n), .rb_n(rb_n), .ra_q(ra_q), .rb_q(rb_q),
		.w_n(w_n), .w_d(w_d), .w_en(w_en)
	);

	sh_ex_stage u_ex (
		.CLK(CLK), .RST_N(RST_N),
		.issue(issue), .op(op), .mem(mem), .size(size),
		.rn(rn), .rm(rm), .imm(imm), .BUS_WAIT(BUS_WAIT),
		.ready(ready), .ex_valid(ex_valid), .ex_done(ex_done),
		.ex_op(ex_op), .ex_mem(ex_mem), .ex_size(ex_size),
		.ex_rn(ex_rn), .ex_imm(ex_imm),
		.ra_n(ra_n), .rb_n(rb_n), .BUS_REQ(BUS_REQ)
	);

	sh_alu u_alu (
		.op(ex_op), .a(ra_q), .b(rb_q), .imm(ex_imm), .t_in(t_cur),
		.res(alu_res), .t_out(alu_t), .t_we(alu_t_we), .r_we(alu_r_we)
	);

	// Address comes from Rm, store data from Rn
	sh_mem_lane u_lane (
		.mem(ex_mem), .size(ex_size), .addr(rb_q), .st_data(ra_q),
		.BUS_DI(BUS_DI), .BUS_A(BUS_A), .BUS_DO(BUS_DO), .BUS_BA(BUS_BA),
		.ld_data(ld_data), .BUS_WR(BUS_WR)
	);

	sh_writeback u_wb (
		.CLK(CLK), .RST_N(RST_N),
		.ex_done(ex_done), .ex_valid(ex_valid), .ex_mem(ex_mem), .ex_rn(ex_rn),
		.alu_res(alu_res), .alu_t(alu_t), .alu_t_we(alu_t_we), .alu_r_we(alu_r_we),
		.ld_data(ld_data),
		.w_n(w_n), .w_d(w_d), .w_en(w_en),
		.wb_valid(wb_valid), .wb_we(wb_we), .wb_reg(wb_reg), .wb_data(wb_data),
		.t_flag(t_flag), .t_cur(t_cur)
	);

endmodule

`default_nettype wire

//--- design/sh_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module sh_writeback (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire                        ex_done,
	input  wire                        ex_valid,
	input  sh_pkg::mem_op_t            ex_mem,
	input  wire [sh_pkg::reg_n_w-1:0]  ex_rn,
	input  wire [sh_pkg::data_w-1:0]   alu_res,
	input  wire                        alu_t,
	input  wire                        alu_t_we,
	input  wire                        alu_r_we,
	input  wire [sh_pkg::data_w-1:0]   ld_data,
	output logic [sh_pkg::reg_n_w-1:0] w_n,
	output logic [sh_pkg::data_w-1:0]  w_d,
	output logic                       w_en,
	output logic                       wb_valid,
	output logic                       wb_we,
	output logic [sh_pkg::reg_n_w-1:0] wb_reg,
	output logic [sh_pkg::data_w-1:0]  wb_data,
	output logic                       t_flag,
	output logic                       t_cur
);

	logic capture;
	logic is_alu;
	logic wb_t;
	logic wb_t_we;

	assign capture = ex_valid & ex_done;
	assign is_alu  = (ex_mem == sh_pkg::MEM_NONE);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wb_valid <= 1'b0;
			wb_we    <= 1'b0;
			wb_t_we  <= 1'b0;
			t_flag   <= 1'b0;
		end else begin
			// Bubble while EX waits on the bus
			wb_valid <= capture;
			if (capture) begin
				wb_we   <= (ex_mem == sh_pkg::MEM_LOAD) | (is_alu & alu_r_we);
				wb_t_we <= is_alu & alu_t_we;
			end
			if (wb_valid && wb_t_we) begin
				t_flag <= wb_t;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (capture) begin
			wb_reg  <= ex_rn;
			wb_data <= (ex_mem == sh_pkg::MEM_LOAD) ? ld_data : alu_res;
			wb_t    <= alu_t;
		end
	end

	assign w_n  = wb_reg;
	assign w_d  = wb_data;
	assign w_en = wb_valid & wb_we;

	// T as the instruction now in EX must see it
	assign t_cur = (wb_valid && wb_t_we) ? wb_t : t_flag;

endmodule

`default_nettype wire

//--- design/sh_mem_lane.sv
`timescale 1ns/1ps
`default_nettype none

module sh_mem_lane (
	input  sh_pkg::mem_op_t            mem,
	input  sh_pkg::mem_size_t          size,
	input  wire [sh_pkg::data_w-1:0]   addr,
	input  wire [sh_pkg::data_w-1:0]   st_data,
	input  wire [sh_pkg::data_w-1:0]   BUS_DI,
	output logic [sh_pkg::data_w-1:0]  BUS_A,
	output logic [sh_pkg::data_w-1:0]  BUS_DO,
	output logic [3:0]                 BUS_BA,
	output logic [sh_pkg::data_w-1:0]  ld_data,
	output logic                       BUS_WR
);

	logic [sh_pkg::data_w-1:0] shifted;

	assign BUS_A  = addr;
	assign BUS_WR = (mem == sh_pkg::MEM_STORE);

	//**********************************************************
	// Big-endian lanes, offset 0 is the top byte
	//**********************************************************
	always_comb begin
		case (size)
			sh_pkg::SZ_BYTE: begin
				BUS_DO  = {4{st_data[7:0]}};
				BUS_BA  = 4'b1000 >> addr[1:0];
				shifted = BUS_DI >> {~addr[1:0], 3'b000};
				ld_data = {{24{shifted[7]}}, shifted[7:0]};
			end
			sh_pkg::SZ_WORD: begin
				BUS_DO  = {2{st_data[15:0]}};
				BUS_BA  = addr[1] ? 4'b0011 : 4'b1100;
				shifted = BUS_DI >> {~addr[1], 4'b0000};
				ld_data = {{16{shifted[15]}}, shifted[15:0]};
			end
			default: begin
				BUS_DO  = st_data;
				BUS_BA  = 4'b1111;
				shifted = BUS_DI;
				ld_data = shifted;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/sh_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sh_alu (
	input  sh_pkg::alu_op_t            op,
	input  wire [sh_pkg::data_w-1:0]   a,
	input  wire [sh_pkg::data_w-1:0]   b,
	input  wire [7:0]                  imm,
	input  wire                        t_in,
	output logic [sh_pkg::data_w-1:0]  res,
	output logic                       t_out,
	output logic                       t_we,
	output logic                       r_we
);

	localparam int w = sh_pkg::data_w;

	logic          sub;
	logic          cin;
	logic [w-1:0]  b_add;
	logic [w:0]    sum;
	logic          ovf;
	logic          ge;
	logic [w-1:0]  log_and;

	//**********************************************************
	// Adder and compare
	//**********************************************************
	assign sub   = op inside {sh_pkg::SUB, sh_pkg::CMP_EQ, sh_pkg::CMP_HS, sh_pkg::CMP_GE};
	assign cin   = sub | ((op == sh_pkg::ADDC) & t_in);
	assign b_add = sub ? ~b : b;
	assign sum   = {1'b0, a} + {1'b0, b_add} + {{w{1'b0}}, cin};

	// Carry out of a - b means no borrow, i.e. a >= b unsigned
	assign ovf = (a[w-1] ^ b[w-1]) & (a[w-1] ^ sum[w-1]);
	assign ge  = ~(sum[w-1] ^ ovf);

	assign log_and = a & b;

	//**********************************************************
	// Result select
	//**********************************************************
	always_comb begin
		res   = b;
		t_out = t_in;
		t_we  = 1'b0;
		r_we  = 1'b1;
		case (op)
			sh_pkg::MOVI:   res = {{(w-8){imm[7]}}, imm};
			sh_pkg::MOV:    res = b;
			sh_pkg::ADD,
			sh_pkg::SUB:    res = sum[w-1:0];
			sh_pkg::ADDC: begin
				res   = sum[w-1:0];
				t_out = sum[w];
				t_we  = 1'b1;
			end
			sh_pkg::AND:    res = log_and;
			sh_pkg::OR:     res = a | b;
			sh_pkg::XOR:    res = a ^ b;
			sh_pkg::TST,
			sh_pkg::CMP_EQ,
			sh_pkg::CMP_HS,
			sh_pkg::CMP_GE: begin
				r_we = 1'b0;
				t_we = 1'b1;
				case (op)
					sh_pkg::TST:    t_out = ~|log_and;
					sh_pkg::CMP_EQ: t_out = ~|sum[w-1:0];
					sh_pkg::CMP_HS: t_out = sum[w];
					default:        t_out = ge;
				endcase
			end
			sh_pkg::SHLL: begin
				res   = {a[w-2:0], 1'b0};
				t_out = a[w-1];
				t_we  = 1'b1;
			end
			sh_pkg::SHLR: begin
				res   = {1'b0, a[w-1:1]};
				t_out = a[0];
				t_we  = 1'b1;
			end
			sh_pkg::EXTU_B: res = {{(w-8){1'b0}}, b[7:0]};
			sh_pkg::EXTS_B: res = {{(w-8){b[7]}}, b[7:0]};
			default:        r_we = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/sh_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module sh_ex_stage (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire                        issue,
	input  sh_pkg::alu_op_t            op,
	input  sh_pkg::mem_op_t            mem,
	input  sh_pkg::mem_size_t          size,
	input  wire [sh_pkg::reg_n_w-1:0]  rn,
	input  wire [sh_pkg::reg_n_w-1:0]  rm,
	input  wire [7:0]                  imm,
	input  wire                        BUS_WAIT,
	output logic                       ready,
	output logic                       ex_valid,
	output logic                       ex_done,
	output sh_pkg::alu_op_t            ex_op,
	output sh_pkg::mem_op_t            ex_mem,
	output sh_pkg::mem_size_t          ex_size,
	output logic [sh_pkg::reg_n_w-1:0] ex_rn,
	output logic [7:0]                 ex_imm,
	output logic [sh_pkg::reg_n_w-1:0] ra_n,
	output logic [sh_pkg::reg_n_w-1:0] rb_n,
	output logic                       BUS_REQ
);

	logic [sh_pkg::reg_n_w-1:0] ex_rm;
	logic                       accept;

	// ex_mem is MEM_NONE whenever EX is empty, so it alone qualifies the bus
	assign BUS_REQ = (ex_mem != sh_pkg::MEM_NONE);
	assign ex_done = ~BUS_REQ | ~BUS_WAIT;
	assign ready   = ex_done;
	assign accept  = issue & ready;

	assign ra_n = ex_rn;
	assign rb_n = ex_rm;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex_valid <= 1'b0;
			ex_mem   <= sh_pkg::MEM_NONE;
			ex_op    <= sh_pkg::NOP;
		end else if (ready) begin
			ex_valid <= issue;
			ex_mem   <= issue ? mem : sh_pkg::MEM_NONE;
			ex_op    <= issue ? op : sh_pkg::NOP;
		end
	end

	// Instruction fields
	always_ff @(posedge CLK) begin
		if (accept) begin
			ex_size <= size;
			ex_rn   <= rn;
			ex_rm   <= rm;
			ex_imm  <= imm;
		end
	end

endmodule

`default_nettype wire

//--- design/sh_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module sh_regfile (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire [sh_pkg::reg_n_w-1:0]  ra_n,
	input  wire [sh_pkg::reg_n_w-1:0]  rb_n,
	output logic [sh_pkg::data_w-1:0]  ra_q,
	output logic [sh_pkg::data_w-1:0]  rb_q,
	input  wire [sh_pkg::reg_n_w-1:0]  w_n,
	input  wire [sh_pkg::data_w-1:0]   w_d,
	input  wire                        w_en
);

	logic [sh_pkg::data_w-1:0] regs [sh_pkg::reg_cnt];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < sh_pkg::reg_cnt; i++) begin
				regs[i] <= '0;
			end
		end else if (w_en) begin
			regs[w_n] <= w_d;
		end
	end

	// Write-first: the value being written this cycle wins
	always_comb begin
		ra_q = (w_en && w_n == ra_n) ? w_d : regs[ra_n];
		rb_q = (w_en && w_n == rb_n) ? w_d : regs[rb_n];
	end

endmodule

`default_nettype wire

//--- design/sh_pkg.sv
`default_nettype none

package sh_pkg;

	// Fixed by the ISA
	localparam int data_w  = 32;
	localparam int reg_n_w = 4;
	localparam int reg_cnt = 1 << reg_n_w;

	// ALU operations
	typedef enum logic [4:0] {
		MOVI,
		MOV,
		ADD,
		ADDC,
		SUB,
		AND,
		OR,
		XOR,
		TST,
		CMP_EQ,
		CMP_HS,
		CMP_GE,
		SHLL,
		SHLR,
		EXTU_B,
		EXTS_B,
		NOP
	} alu_op_t;

	// Memory access kind; address from Rm, store data from Rn
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_t;

	typedef enum logic [1:0] {
		SZ_BYTE,
		SZ_WORD,
		SZ_LONG
	} mem_size_t;

endpackage

`default_nettype wire
